// ==== flist.f ====
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
decode_if.sv
service_if.sv
instr_decoder.sv
service_arbiter.sv
major_state_seq.sv
cpu_control_top.sv
tb_cpu_control.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_cpu_control -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "^All tests passed$" sim.log; then
    echo "RESULT: PASS"
else
    echo "RESULT: FAIL"
    exit 1
fi

// ==== tb_cpu_control.sv ====
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module tb_cpu_control;

    localparam int MAX_ROWS    = 24;
    localparam int MAX_TRACE   = 12;
    localparam int TRACE_W     = `CPU_STATE_W * MAX_TRACE;
    localparam int ROW_TIMEOUT = 40;

    // Control levels of a table row are ORed together
    localparam logic [7:0] NONE   = 8'h00;
    localparam logic [7:0] CONT   = 8'h01;
    localparam logic [7:0] HALT   = 8'h02;
    localparam logic [7:0] INT    = 8'h04;   // int_req with int_ena
    localparam logic [7:0] UF     = 8'h08;
    localparam logic [7:0] MODE_B = 8'h10;
    localparam logic [7:0] LOOP   = 8'h20;
    localparam logic [7:0] DBW    = 8'h40;
    localparam logic [7:0] DBR    = 8'h80;

    logic                    clk;
    logic                    reset;
    logic                    halt, single_step, cont, trigger;
    logic                    int_req, int_ena, int_inh, uf;
    logic                    eae_mode, eae_loop, gtf, db_write, db_read;
    logic [`CPU_WORD_W-1:0]  instruction, ac, mq;
    logic                    eae_skip;
    logic                    int_in_prog;
    logic [`CPU_STATE_W-1:0] state;

    string                   row_name [MAX_ROWS];
    logic [`CPU_WORD_W-1:0]  row_instr [MAX_ROWS];
    logic [`CPU_WORD_W-1:0]  row_ac [MAX_ROWS];
    logic [`CPU_WORD_W-1:0]  row_mq [MAX_ROWS];
    logic [7:0]              row_ctrl [MAX_ROWS];
    logic                    row_skip [MAX_ROWS];    // eae_skip at end of trace
    logic                    row_iip [MAX_ROWS];     // int_in_prog at end of trace
    int                      row_len [MAX_ROWS];
    logic [TRACE_W-1:0]      row_trace [MAX_ROWS];   // First state in the top bits
    int                      nrows;
    int                      errors;
    int                      checks;

    cpu_control_top u_cpu_control_top
    (
        .clk         (clk),
        .reset       (reset),
        .halt        (halt),
        .single_step (single_step),
        .cont        (cont),
        .int_req     (int_req),
        .int_ena     (int_ena),
        .int_inh     (int_inh),
        .uf          (uf),
        .trigger     (trigger),
        .instruction (instruction),
        .ac          (ac),
        .mq          (mq),
        .eae_mode    (eae_mode),
        .eae_loop    (eae_loop),
        .gtf         (gtf),
        .db_write    (db_write),
        .db_read     (db_read),
        .eae_skip    (eae_skip),
        .int_in_prog (int_in_prog),
        .state       (state)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            $display("mismatch %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic add_row(input string name, input logic [`CPU_WORD_W-1:0] instr_v,
                           input logic [`CPU_WORD_W-1:0] ac_v,
                           input logic [`CPU_WORD_W-1:0] mq_v, input logic [7:0] ctrl_v,
                           input logic skip_v, input logic iip_v, input int len_v,
                           input logic [TRACE_W-1:0] trace_v);
        row_name[nrows]  = name;
        row_instr[nrows] = instr_v;
        row_ac[nrows]    = ac_v;
        row_mq[nrows]    = mq_v;
        row_ctrl[nrows]  = ctrl_v;
        row_skip[nrows]  = skip_v;
        row_iip[nrows]   = iip_v;
        row_len[nrows]   = len_v;
        row_trace[nrows] = trace_v;
        nrows++;
    endtask

    task automatic apply_row(input int r);
        instruction <= row_instr[r];
        ac          <= row_ac[r];
        mq          <= row_mq[r];
        cont        <= (row_ctrl[r] & CONT) != 8'h00;
        halt        <= (row_ctrl[r] & HALT) != 8'h00;
        int_req     <= (row_ctrl[r] & INT) != 8'h00;
        int_ena     <= (row_ctrl[r] & INT) != 8'h00;
        uf          <= (row_ctrl[r] & UF) != 8'h00;
        eae_mode    <= (row_ctrl[r] & MODE_B) != 8'h00;
        eae_loop    <= (row_ctrl[r] & LOOP) != 8'h00;
        db_write    <= (row_ctrl[r] & DBW) != 8'h00;
        db_read     <= (row_ctrl[r] & DBR) != 8'h00;
    endtask

    // Each trace starts where the previous row left the DUT
    task automatic load_table();
        add_row("reset_cont", 12'o7000, 12'o0, 12'o0, CONT, 1'b0, 1'b0, 3,
            TRACE_W'({ctrl_pkg::H0, ctrl_pkg::HW, ctrl_pkg::F0}));
        add_row("opr_7000", 12'o7000, 12'o0, 12'o0, NONE, 1'b0, 1'b0, 6,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2, ctrl_pkg::F3,
                      ctrl_pkg::F0}));
        add_row("mri_direct", 12'o1000, 12'o0, 12'o0, NONE, 1'b0, 1'b0, 11,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2, ctrl_pkg::F3,
                      ctrl_pkg::E0, ctrl_pkg::EW, ctrl_pkg::E1, ctrl_pkg::E2, ctrl_pkg::E3,
                      ctrl_pkg::F0}));
        add_row("mri_indirect", 12'o1400, 12'o0, 12'o0, NONE, 1'b0, 1'b0, 11,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2, ctrl_pkg::F3,
                      ctrl_pkg::D0, ctrl_pkg::DW, ctrl_pkg::D1, ctrl_pkg::D2, ctrl_pkg::D3,
                      ctrl_pkg::E0}));
        add_row("mri_indirect_exec", 12'o1400, 12'o0, 12'o0, NONE, 1'b0, 1'b0, 6,
            TRACE_W'({ctrl_pkg::E0, ctrl_pkg::EW, ctrl_pkg::E1, ctrl_pkg::E2, ctrl_pkg::E3,
                      ctrl_pkg::F0}));
        add_row("int_entry", 12'o7000, 12'o0, 12'o0, INT, 1'b0, 1'b1, 11,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2, ctrl_pkg::F3,
                      ctrl_pkg::E0, ctrl_pkg::EW, ctrl_pkg::E1, ctrl_pkg::E2, ctrl_pkg::E3,
                      ctrl_pkg::F0}));
        add_row("iof_no_int", 12'o6002, 12'o0, 12'o0, INT, 1'b0, 1'b0, 6,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2, ctrl_pkg::F3,
                      ctrl_pkg::F0}));
        add_row("break_write", 12'o7000, 12'o0, 12'o0, DBW, 1'b0, 1'b0, 9,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2, ctrl_pkg::F3,
                      ctrl_pkg::DB0, ctrl_pkg::DB1, ctrl_pkg::DB2, ctrl_pkg::F0}));
        add_row("break_read", 12'o7000, 12'o0, 12'o0, DBR, 1'b0, 1'b0, 8,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2, ctrl_pkg::F3,
                      ctrl_pkg::DB0, ctrl_pkg::DB1, ctrl_pkg::F0}));
        add_row("hlt_instr", 12'o7402, 12'o0, 12'o0, NONE, 1'b0, 1'b0, 6,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2, ctrl_pkg::F3,
                      ctrl_pkg::H0}));
        add_row("hlt_resume", 12'o7000, 12'o0, 12'o0, CONT, 1'b0, 1'b0, 3,
            TRACE_W'({ctrl_pkg::H0, ctrl_pkg::HW, ctrl_pkg::F0}));
        add_row("hlt_user_mode", 12'o7402, 12'o0, 12'o0, UF, 1'b0, 1'b0, 6,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2, ctrl_pkg::F3,
                      ctrl_pkg::F0}));
        add_row("halt_input", 12'o7000, 12'o0, 12'o0, HALT, 1'b0, 1'b0, 6,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2, ctrl_pkg::F3,
                      ctrl_pkg::H0}));
        add_row("halt_resume", 12'o7000, 12'o0, 12'o0, CONT, 1'b0, 1'b0, 3,
            TRACE_W'({ctrl_pkg::H0, ctrl_pkg::HW, ctrl_pkg::F0}));
        add_row("dpsz_zero", 12'o7451, 12'o0, 12'o0, MODE_B, 1'b1, 1'b0, 6,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2B, ctrl_pkg::F3,
                      ctrl_pkg::F0}));
        add_row("dpsz_nonzero", 12'o7451, 12'o0001, 12'o0, MODE_B, 1'b0, 1'b0, 6,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2B, ctrl_pkg::F3,
                      ctrl_pkg::F0}));
        add_row("shl_loop", 12'o7413, 12'o0, 12'o0, LOOP, 1'b1, 1'b0, 8,
            TRACE_W'({ctrl_pkg::F0, ctrl_pkg::FW, ctrl_pkg::F1, ctrl_pkg::F2A, ctrl_pkg::EAE0,
                      ctrl_pkg::EAE1, ctrl_pkg::EAE1, ctrl_pkg::EAE1}));
        add_row("shl_done", 12'o7413, 12'o0, 12'o0, NONE, 1'b1, 1'b0, 3,
            TRACE_W'({ctrl_pkg::EAE1, ctrl_pkg::F3, ctrl_pkg::F0}));
    endtask

    initial
    begin
        int                      r;
        int                      k;
        int                      cycles;
        logic                    row_done;
        logic [`CPU_STATE_W-1:0] want;

        errors      = 0;
        checks      = 0;
        nrows       = 0;
        reset       <= 1'b1;
        halt        <= 1'b0;
        single_step <= 1'b0;
        cont        <= 1'b0;
        trigger     <= 1'b0;
        int_req     <= 1'b0;
        int_ena     <= 1'b0;
        int_inh     <= 1'b0;
        uf          <= 1'b0;
        eae_mode    <= 1'b0;
        eae_loop    <= 1'b0;
        gtf         <= 1'b0;
        db_write    <= 1'b0;
        db_read     <= 1'b0;
        instruction <= '0;
        ac          <= '0;
        mq          <= '0;
        load_table();

        repeat (16)
            @(posedge clk);
        reset <= 1'b0;
        apply_row(0);
        @(negedge clk);
        check_value("reset eae_skip", 32'd0, 32'(eae_skip));
        check_value("reset int_in_prog", 32'd0, 32'(int_in_prog));

        for (r = 0; r < nrows; r++)
        begin
            k        = 0;
            cycles   = 0;
            row_done = 1'b0;
            while (!row_done && cycles < ROW_TIMEOUT)
            begin
                if (k > 0)
                begin
                    @(posedge clk);
                    if (k == row_len[r] - 1 && r + 1 < nrows)
                        apply_row(r + 1);   // Next row owns the following transition
                    @(negedge clk);
                    cycles++;
                end
                if (k < row_len[r])
                begin
                    want = row_trace[r][`CPU_STATE_W*(row_len[r]-1-k) +: `CPU_STATE_W];
                    check_value($sformatf("%s state %0d", row_name[r], k),
                                32'(want), 32'(state));
                end
                // A late DUT is followed until it reaches the final state
                row_done = (k >= row_len[r] - 1)
                           && (state == row_trace[r][`CPU_STATE_W-1:0]);
                k++;
            end
            if (!row_done)
            begin
                $display("timeout in %s after %0d cycles", row_name[r], cycles);
                errors++;
            end
            check_value({row_name[r], " eae_skip"}, 32'(row_skip[r]), 32'(eae_skip));
            check_value({row_name[r], " int_in_prog"}, 32'(row_iip[r]), 32'(int_in_prog));
        end

        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== cpu_control_top.sv ====
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module cpu_control_top
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    halt,
    input  logic                    single_step,
    input  logic                    cont,
    input  logic                    int_req,
    input  logic                    int_ena,
    input  logic                    int_inh,
    input  logic                    uf,
    input  logic                    trigger,
    input  logic [`CPU_WORD_W-1:0]  instruction,
    input  logic [`CPU_WORD_W-1:0]  ac,
    input  logic [`CPU_WORD_W-1:0]  mq,
    input  logic                    eae_mode,
    input  logic                    eae_loop,
    input  logic                    gtf,
    input  logic                    db_write,
    input  logic                    db_read,
    output logic                    eae_skip,
    output logic                    int_in_prog,
    output logic [`CPU_STATE_W-1:0] state
);

    decode_if  dec_bus ();
    service_if svc_bus ();

    instr_decoder u_instr_decoder
    (
        .instruction (instruction),
        .ac          (ac),
        .mq          (mq),
        .gtf         (gtf),
        .uf          (uf),
        .dec         (dec_bus.dec)
    );

    service_arbiter u_service_arbiter
    (
        .clk         (clk),
        .reset       (reset),
        .halt        (halt),
        .int_req     (int_req),
        .int_ena     (int_ena),
        .int_inh     (int_inh),
        .db_write    (db_write),
        .db_read     (db_read),
        .int_in_prog (int_in_prog),
        .iclass      (dec_bus.iclass),
        .svc         (svc_bus.arb)
    );

    major_state_seq u_major_state_seq
    (
        .clk         (clk),
        .reset       (reset),
        .single_step (single_step),
        .cont        (cont),
        .trigger     (trigger),
        .eae_mode    (eae_mode),
        .eae_loop    (eae_loop),
        .dec         (dec_bus.seq),
        .svc         (svc_bus.seq),
        .state       (state),
        .eae_skip    (eae_skip),
        .int_in_prog (int_in_prog)
    );

endmodule

// ==== major_state_seq.sv ====
`timescale 1ns/100ps

module major_state_seq
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 single_step,
    input  logic                 cont,
    input  logic                 trigger,
    input  logic                 eae_mode,    // 0 = mode A, 1 = mode B
    input  logic                 eae_loop,
    decode_if.seq                dec,
    service_if.seq               svc,
    output ctrl_pkg::major_state_e state,
    output logic                 eae_skip,
    output logic                 int_in_prog
);

    ctrl_pkg::major_state_e ret_state;   // Resume point after a data break
    ctrl_pkg::major_state_e mem_dest;
    logic                   go;
    logic                   fetch_done;

    assign go = !single_step || cont;

    assign fetch_done = !(dec.iclass inside {isa_pkg::IC_MRI_DIR, isa_pkg::IC_MRI_IND,
                                             isa_pkg::IC_JMP_IND});

    assign mem_dest = (dec.iclass == isa_pkg::IC_MRI_DIR) ? ctrl_pkg::E0 : ctrl_pkg::D0;

    assign svc.in_break = (state == ctrl_pkg::DB0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= ctrl_pkg::H0;
            int_in_prog <= 1'b0;
            eae_skip    <= 1'b0;
        end
        else
        begin
            case (state)
                ctrl_pkg::F0:
                begin
                    if (go)
                        state <= ctrl_pkg::FW;
                    int_in_prog <= 1'b0;
                    eae_skip    <= 1'b0;
                end
                ctrl_pkg::FW: state <= ctrl_pkg::F1;
                ctrl_pkg::F1:
                begin
                    if (dec.iclass != isa_pkg::IC_EAE)
                        state <= ctrl_pkg::F2;
                    else if (eae_mode)
                        state <= ctrl_pkg::F2B;
                    else
                        state <= ctrl_pkg::F2A;
                end
                ctrl_pkg::F2: state <= ctrl_pkg::F3;
                ctrl_pkg::F2A:
                begin
                    if (dec.eae_a_skip)
                        eae_skip <= 1'b1;
                    if (dec.eae_op inside {isa_pkg::EAE_NOP, isa_pkg::EAE_SCA})
                        state <= ctrl_pkg::F3;
                    else
                        state <= ctrl_pkg::EAE0;
                end
                ctrl_pkg::F2B:
                begin
                    if (dec.eae_b_skip)
                        eae_skip <= 1'b1;
                    case (dec.eae_op)
                        isa_pkg::EAE_MUY,
                        isa_pkg::EAE_DIV,
                        isa_pkg::EAE_SCA,
                        isa_pkg::EAE_DAD_DST: state <= ctrl_pkg::D0;   // Need the operand
                        isa_pkg::EAE_NMI,
                        isa_pkg::EAE_SHL,
                        isa_pkg::EAE_ASR,
                        isa_pkg::EAE_LSR:     state <= ctrl_pkg::EAE0;
                        default:              state <= ctrl_pkg::F3;
                    endcase
                end
                ctrl_pkg::F3:
                begin
                    if (fetch_done)
                    begin
                        if (svc.halt_req)
                            state <= ctrl_pkg::H0;
                        else if (dec.iclass == isa_pkg::IC_HLT)
                            state <= ctrl_pkg::H0;
                        else if (svc.int_grant)
                        begin
                            int_in_prog <= 1'b1;
                            state       <= ctrl_pkg::E0;
                        end
                        else if (svc.break_pending)
                        begin
                            ret_state <= ctrl_pkg::F0;
                            state     <= ctrl_pkg::DB0;
                        end
                        else
                            state <= ctrl_pkg::F0;
                    end
                    else if (svc.break_pending)
                    begin
                        ret_state <= mem_dest;
                        state     <= ctrl_pkg::DB0;
                    end
                    else
                        state <= mem_dest;
                end

                ctrl_pkg::D0:
                begin
                    if (go)
                        state <= ctrl_pkg::DW;
                end
                ctrl_pkg::DW: state <= ctrl_pkg::D1;
                ctrl_pkg::D1: state <= ctrl_pkg::D2;
                ctrl_pkg::D2: state <= ctrl_pkg::D3;
                ctrl_pkg::D3:
                begin
                    if (dec.iclass == isa_pkg::IC_JMP_IND)   // JMP I ends here
                    begin
                        if (svc.int_grant)
                        begin
                            int_in_prog <= 1'b1;
                            state       <= ctrl_pkg::E0;
                        end
                        else if (svc.halt_req)
                            state <= ctrl_pkg::H0;
                        else
                            state <= ctrl_pkg::F0;
                    end
                    else if (dec.iclass == isa_pkg::IC_EAE)
                        state <= ctrl_pkg::EAE2;
                    else
                        state <= ctrl_pkg::E0;
                end

                ctrl_pkg::E0:
                begin
                    if (go)
                        state <= ctrl_pkg::EW;
                end
                ctrl_pkg::EW: state <= ctrl_pkg::E1;
                ctrl_pkg::E1: state <= ctrl_pkg::E2;
                ctrl_pkg::E2: state <= ctrl_pkg::E3;
                ctrl_pkg::E3:
                begin
                    if (svc.halt_req)
                        state <= ctrl_pkg::H0;
                    else if (int_in_prog)               // Vector already taken
                        state <= ctrl_pkg::F0;
                    else if (svc.int_grant)
                    begin
                        int_in_prog <= 1'b1;
                        state       <= ctrl_pkg::E0;
                    end
                    else
                        state <= ctrl_pkg::F0;
                end

                ctrl_pkg::H0: state <= ctrl_pkg::HW;
                ctrl_pkg::HW:
                begin
                    if (cont)
                        state <= ctrl_pkg::F0;
                    else if (trigger)
                        state <= ctrl_pkg::H1;          // Panel cycle
                    else
                        state <= ctrl_pkg::H0;
                end
                ctrl_pkg::H1: state <= ctrl_pkg::H2;
                ctrl_pkg::H2: state <= ctrl_pkg::H3;
                ctrl_pkg::H3: state <= ctrl_pkg::H0;

                ctrl_pkg::EAE0: state <= ctrl_pkg::EAE1;
                ctrl_pkg::EAE1:
                begin
                    if (!eae_loop)
                        state <= ctrl_pkg::F3;
                end
                ctrl_pkg::EAE2: state <= ctrl_pkg::EAE3;
                ctrl_pkg::EAE3:
                begin
                    // Mode B multiply and divide continue in the loop states
                    if (dec.eae_is_muldiv)
                        state <= ctrl_pkg::EAE0;
                    else
                        state <= ctrl_pkg::EAE4;
                end
                ctrl_pkg::EAE4: state <= ctrl_pkg::EAE5;
                ctrl_pkg::EAE5: state <= ctrl_pkg::E3;

                ctrl_pkg::DB0: state <= ctrl_pkg::DB1;
                ctrl_pkg::DB1:
                begin
                    if (svc.break_write)
                        state <= ctrl_pkg::DB2;
                    else
                        state <= ret_state;             // Read is one cycle shorter
                end
                ctrl_pkg::DB2: state <= ret_state;

                default: state <= ctrl_pkg::H0;
            endcase
        end
    end

endmodule

// ==== service_arbiter.sv ====
`timescale 1ns/100ps

module service_arbiter
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  halt,
    input  logic                  int_req,
    input  logic                  int_ena,
    input  logic                  int_inh,
    input  logic                  db_write,     // Write from the disk side
    input  logic                  db_read,
    input  logic                  int_in_prog,
    input  isa_pkg::instr_class_e iclass,
    service_if.arb                svc
);

    logic break_dir_q;

    assign svc.halt_req = halt;

    // IOF must not be followed by an interrupt in the same fetch,
    // or ION/IOF sequences would lose the IOF
    assign svc.int_grant = int_req && int_ena && !int_inh && !int_in_prog
                           && (iclass != isa_pkg::IC_IOF);

    assign svc.break_pending = db_write || db_read;

    // Direction sampled in DB0 so DB1 sees a stable value
    always_ff @(posedge clk)
    begin
        if (reset)
            break_dir_q <= 1'b0;
        else if (svc.in_break)
            break_dir_q <= db_write;
    end

    assign svc.break_write = break_dir_q;

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module instr_decoder
(
    input  logic [`CPU_WORD_W-1:0] instruction,
    input  logic [`CPU_WORD_W-1:0] ac,
    input  logic [`CPU_WORD_W-1:0] mq,
    input  logic                   gtf,
    input  logic                   uf,
    decode_if.dec                  dec
);

    logic       is_eae;
    logic       is_hlt;
    logic [3:0] eae_key;

    // Bit 6 and bits 8-10 in the manual's numbering
    assign eae_key = {instruction[5], instruction[3:1]};

    // 7401 is a plain operate NOP and 7447 (SWBA) completes in F2
    assign is_eae = (instruction[11:8] == 4'b1111) && instruction[0]
                    && (eae_key != 4'b0000) && (eae_key != 4'b1011);

    assign is_hlt = ({instruction[11:8], instruction[1:0]} == 6'b111110);

    always_comb
    begin
        if (is_eae)
            dec.iclass = isa_pkg::IC_EAE;
        else if (is_hlt && !uf)                 // User mode traps HLT instead
            dec.iclass = isa_pkg::IC_HLT;
        else if (instruction == 12'o6002)
            dec.iclass = isa_pkg::IC_IOF;
        else if (instruction[11:10] == 2'b11)
            dec.iclass = isa_pkg::IC_IOT_OPR;
        else if (instruction[11:8] == 4'b1011)
            dec.iclass = isa_pkg::IC_JMP_IND;
        else if (instruction[11:8] == 4'b1010)
            dec.iclass = isa_pkg::IC_OTHER;
        else if (instruction[8])                // Indirect bit
            dec.iclass = isa_pkg::IC_MRI_IND;
        else
            dec.iclass = isa_pkg::IC_MRI_DIR;
    end

    always_comb
    begin
        if (!is_eae)
            dec.eae_op = isa_pkg::EAE_NONE;
        else
            case (eae_key)
                4'b0001: dec.eae_op = isa_pkg::EAE_SCL;
                4'b0010: dec.eae_op = isa_pkg::EAE_MUY;
                4'b0011: dec.eae_op = isa_pkg::EAE_DIV;
                4'b0100: dec.eae_op = isa_pkg::EAE_NMI;
                4'b0101: dec.eae_op = isa_pkg::EAE_SHL;
                4'b0110: dec.eae_op = isa_pkg::EAE_ASR;
                4'b0111: dec.eae_op = isa_pkg::EAE_LSR;
                4'b1000: dec.eae_op = isa_pkg::EAE_NOP;     // SCA alone
                4'b1001: dec.eae_op = isa_pkg::EAE_SCA;
                4'b1010: dec.eae_op = isa_pkg::EAE_DAD_DST;
                4'b1100: dec.eae_op = isa_pkg::EAE_DPSZ;
                4'b1101,
                4'b1110,
                4'b1111: dec.eae_op = isa_pkg::EAE_SIMPLE;
                default: dec.eae_op = isa_pkg::EAE_NONE;
            endcase
    end

    assign dec.mode_b_skip = ((dec.eae_op == isa_pkg::EAE_DPSZ) && ((ac | mq) == '0))
                             || ((instruction == 12'o6006) && gtf);

    // Mode A skips on every op except NOP, NMI and the bare SCA forms
    assign dec.eae_a_skip = is_eae && (instruction[2:1] != 2'b00);

    assign dec.eae_b_skip = dec.mode_b_skip
                            || (dec.eae_op inside {isa_pkg::EAE_MUY, isa_pkg::EAE_DIV,
                                                   isa_pkg::EAE_SHL, isa_pkg::EAE_ASR,
                                                   isa_pkg::EAE_LSR, isa_pkg::EAE_SCA,
                                                   isa_pkg::EAE_DAD_DST});

    assign dec.eae_is_muldiv = !instruction[5];

endmodule

// ==== service_if.sv ====
`timescale 1ns/100ps

interface service_if;

    logic halt_req;
    logic int_grant;     // Interrupt may be taken now
    logic break_pending;
    logic break_write;   // Direction held from DB0
    logic in_break;      // Back from the sequencer

    modport arb
    (
        output halt_req, int_grant, break_pending, break_write,
        input  in_break
    );

    modport seq
    (
        input  halt_req, int_grant, break_pending, break_write,
        output in_break
    );

endinterface

// ==== decode_if.sv ====
`timescale 1ns/100ps

interface decode_if;

    isa_pkg::instr_class_e iclass;
    isa_pkg::eae_op_e      eae_op;
    logic                  mode_b_skip;   // DPSZ zero or 6006 with gtf
    logic                  eae_a_skip;    // Skip flag on F2A exit
    logic                  eae_b_skip;    // Skip flag on F2B exit
    logic                  eae_is_muldiv; // Bit 6 clear sends EAE3 to EAE0

    modport dec
    (
        output iclass, eae_op, mode_b_skip, eae_a_skip, eae_b_skip, eae_is_muldiv
    );

    modport seq
    (
        input iclass, eae_op, mode_b_skip, eae_a_skip, eae_b_skip, eae_is_muldiv
    );

endinterface

// ==== ctrl_pkg.sv ====
`include "cpu_cfg.svh"

package ctrl_pkg;

    typedef enum logic [`CPU_STATE_W-1:0]
    {
        F0, FW, F1, F2, F2A, F2B, F3,       // Fetch
        D0, DW, D1, D2, D3,                 // Defer
        E0, EW, E1, E2, E3,                 // Execute
        H0, HW, H1, H2, H3,                 // Halt
        EAE0, EAE1, EAE2, EAE3, EAE4, EAE5, // Extended arithmetic
        DB0, DB1, DB2                       // Data break
    } major_state_e;

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

    // Coarse class of the instruction word, used by F3 and D3
    typedef enum logic [2:0]
    {
        IC_MRI_DIR,   // Direct opcodes 0-4
        IC_MRI_IND,   // Indirect opcodes 0-4
        IC_JMP_IND,   // JMP I
        IC_IOT_OPR,   // IOT and operate group
        IC_HLT,       // HLT outside user mode
        IC_IOF,       // 6002 never takes an interrupt
        IC_EAE,       // Extended arithmetic
        IC_OTHER      // Direct JMP, done at end of fetch
    } instr_class_e;

    // EAE code from bit 6 and bits 8-10 of the word
    // Routing per mode is done in the sequencer
    typedef enum logic [3:0]
    {
        EAE_NOP,      // SCA alone (7441)
        EAE_SCL,
        EAE_MUY,
        EAE_DIV,
        EAE_NMI,
        EAE_SHL,
        EAE_ASR,
        EAE_LSR,
        EAE_SCA,      // SCA with SCL in mode A, DAD in mode B
        EAE_DAD_DST,  // DST in mode B, SCA with MUY in mode A
        EAE_DPSZ,
        EAE_SIMPLE,   // DPIC, DCM, SAM
        EAE_NONE
    } eae_op_e;

endpackage

// ==== cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Machine word width for instruction, AC and MQ
`define CPU_WORD_W 12

// Major-state code wide enough for all 31 states
`define CPU_STATE_W 5

`endif
